/* r22sdf_stage.f */
fft_num_pkg.sv
sdf_ctrl_pkg.sv
feedback_delay.sv
sdf_bf1.sv
sdf_bf2.sv
twiddle_gen.sv
twiddle_mult.sv
r22sdf_stage.sv
tb_clk_gen.sv
tb_r22sdf_stage.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_r22sdf_stage -f r22sdf_stage.f -o sim_r22sdf_stage
./obj_dir/sim_r22sdf_stage > sim.log 2>&1
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi

/* tb_r22sdf_stage.sv */
module tb_r22sdf_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_LEN     = 16;
    localparam int QUARTER       = FRAME_LEN / 4;
    localparam int TAIL_LEN      = 3 * QUARTER;  // Pushes the last frame out of the pipeline
    localparam int FRAMES_DRIVEN = 22;
    localparam int TAILS_DRIVEN  = 6;
    localparam int TOTAL_SAMPLES = FRAMES_DRIVEN * FRAME_LEN + TAILS_DRIVEN * TAIL_LEN;
    localparam int TIMEOUT       = TOTAL_SAMPLES * 4 + 200;
    localparam int DRAIN_LIMIT   = 16;           // Quiet cycles before outputs count as missing
    localparam int OW            = fft_num_pkg::IN_WIDTH + 3;

    logic                                  clk;
    logic                                  rst;
    logic                                  rst_req;
    logic signed [fft_num_pkg::IN_WIDTH-1:0] din_re;
    logic signed [fft_num_pkg::IN_WIDTH-1:0] din_im;
    logic                                  din_valid;
    logic signed [OW-1:0]                  dout_re;
    logic signed [OW-1:0]                  dout_im;
    logic                                  dout_valid;

    fft_num_pkg::out_cplx_t exp_q[$];
    fft_num_pkg::in_cplx_t  frame_buf[FRAME_LEN];
    string                  test_name = "startup";
    int                     out_cnt = 0;
    int                     err_cnt = 0;
    int                     err_base = 0;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    int                     cycle_cnt = 0;

    tb_clk_gen i_tb_clk_gen (
        .rst_req (rst_req),
        .clk     (clk),
        .rst     (rst)
    );

    r22sdf_stage #(
        .FRAME_LEN (FRAME_LEN)
    ) i_r22sdf_stage (
        .clk        (clk),
        .rst        (rst),
        .din_re     (din_re),
        .din_im     (din_im),
        .din_valid  (din_valid),
        .dout_re    (dout_re),
        .dout_im    (dout_im),
        .dout_valid (dout_valid)
    );

    function automatic int round_real(real v);
        if (v >= 0.0) begin
            return $rtoi(v + 0.5);
        end
        return -$rtoi(0.5 - v);
    endfunction

    // Real and imaginary part of (-j)^e
    function automatic int neg_j_re(int e);
        case (e % 4)
            0:       return 1;
            2:       return -1;
            default: return 0;
        endcase
    endfunction

    function automatic int neg_j_im(int e);
        case (e % 4)
            1:       return -1;
            3:       return 1;
            default: return 0;
        endcase
    endfunction

    task automatic check_sample(input int idx, input fft_num_pkg::out_cplx_t expected,
                                input fft_num_pkg::out_cplx_t actual);
        if (actual !== expected) begin
            err_cnt++;
            $display("** Error %s sample %0d: expected (%0d, %0d), actual (%0d, %0d)",
                     test_name, idx, expected.re, expected.im, actual.re, actual.im);
        end
    endtask

    task automatic check_count(input int frames, input int got);
        int expected;
        expected = frames * FRAME_LEN;
        if (got < expected) begin
            err_cnt++;
            $display("%s: %0d outputs are missing, only %0d of %0d arrived",
                     test_name, expected - got, got, expected);
        end else if (got > expected) begin
            err_cnt++;
            $display("%s: %0d surplus outputs beyond the %0d expected",
                     test_name, got - expected, expected);
        end
    endtask

    // Expected outputs of frame_buf in emission order, blocks k = 0, 2, 1, 3
    task automatic push_expected();
        int                     q;
        int                     r;
        int                     k;
        int                     idx;
        longint                 a_re;
        longint                 a_im;
        longint                 x_re;
        longint                 x_im;
        longint                 w_re;
        longint                 w_im;
        longint                 p_re;
        longint                 p_im;
        real                    ang;
        fft_num_pkg::out_cplx_t y;
        for (int m = 0; m < FRAME_LEN; m++) begin
            q    = m / QUARTER;
            r    = m % QUARTER;
            k    = ((q & 1) << 1) | (q >> 1);
            a_re = 0;
            a_im = 0;
            for (int p = 0; p < 4; p++) begin
                idx  = p * QUARTER + r;
                x_re = frame_buf[idx].re;
                x_im = frame_buf[idx].im;
                a_re += x_re * neg_j_re(p * k) - x_im * neg_j_im(p * k);
                a_im += x_re * neg_j_im(p * k) + x_im * neg_j_re(p * k);
            end
            ang  = 2.0 * 3.14159265358979323846 * (r * k) / FRAME_LEN;
            w_re = round_real($cos(ang) * real'(1 << fft_num_pkg::TW_FRAC));
            w_im = round_real(-$sin(ang) * real'(1 << fft_num_pkg::TW_FRAC));
            p_re = (a_re * w_re - a_im * w_im) >>> fft_num_pkg::TW_FRAC;
            p_im = (a_re * w_im + a_im * w_re) >>> fft_num_pkg::TW_FRAC;
            y.re = p_re[OW-1:0];
            y.im = p_im[OW-1:0];
            if (p_re != y.re || p_im != y.im) begin
                err_cnt++;
                $display("%s: exact result of frame sample %0d does not fit in %0d bits",
                         test_name, m, OW);
            end
            exp_q.push_back(y);
        end
    endtask

    task automatic drive_sample(input fft_num_pkg::in_cplx_t s, input bit gaps);
        int idle;
        idle = gaps ? $urandom_range(0, 2) : 0;
        repeat (idle) begin
            @(negedge clk);
            din_valid = 1'b0;
        end
        @(negedge clk);
        din_re    = s.re;
        din_im    = s.im;
        din_valid = 1'b1;
    endtask

    task automatic stop_input();
        @(negedge clk);
        din_valid = 1'b0;
    endtask

    task automatic drive_frame(input bit gaps);
        push_expected();
        for (int n = 0; n < FRAME_LEN; n++) begin
            drive_sample(frame_buf[n], gaps);
        end
    endtask

    // Leading samples of frame_buf with no model entry
    task automatic drive_partial(input int len, input bit gaps);
        for (int n = 0; n < len; n++) begin
            drive_sample(frame_buf[n], gaps);
        end
        stop_input();
    endtask

    task automatic clear_frame();
        for (int n = 0; n < FRAME_LEN; n++) begin
            frame_buf[n] = '0;
        end
    endtask

    task automatic fill_random();
        for (int n = 0; n < FRAME_LEN; n++) begin
            frame_buf[n].re = 16'($urandom);
            frame_buf[n].im = 16'($urandom);
        end
    endtask

    task automatic drive_tail(input bit gaps);
        clear_frame();
        drive_partial(TAIL_LEN, gaps);
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        din_valid = 1'b0;
        rst_req   = 1'b1;
        repeat (2) @(negedge clk);
        rst_req = 1'b0;
        exp_q.delete();
        out_cnt = 0;
    endtask

    task automatic wait_outputs(input int n);
        int quiet;
        int last;
        quiet = 0;
        last  = out_cnt;
        while (out_cnt < n && quiet < DRAIN_LIMIT) begin
            @(negedge clk);
            if (out_cnt != last) begin
                last  = out_cnt;
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        repeat (8) @(negedge clk);  // Room for a surplus output to show up
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_base  = err_cnt;
        pulse_reset();
    endtask

    task automatic finish_test(input int frames);
        wait_outputs(frames * FRAME_LEN);
        check_count(frames, out_cnt);
        tests_run++;
        if (err_cnt != err_base) begin
            tests_failed++;
        end
        $display("%-13s: %s, %0d outputs, %0d errors", test_name,
                 (err_cnt == err_base) ? "ok" : "FAILED", out_cnt, err_cnt - err_base);
    endtask

    // Outputs are register driven and settled by the falling edge
    always @(negedge clk) begin : output_monitor
        fft_num_pkg::out_cplx_t got;
        if (dout_valid === 1'b1) begin
            got.re = dout_re;
            got.im = dout_im;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("%s: output %0d arrived with no expected sample left",
                         test_name, out_cnt);
            end else begin
                check_sample(out_cnt, exp_q.pop_front(), got);
            end
            out_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles, stuck in %s",
                     TIMEOUT, test_name);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(28943));
        rst_req   = 1'b0;
        din_re    = '0;
        din_im    = '0;
        din_valid = 1'b0;
        while (rst !== 1'b0) begin
            @(negedge clk);
        end

        start_test("impulse");
        clear_frame();
        frame_buf[0].re = 16'sd1000;
        drive_frame(1'b0);
        drive_tail(1'b0);
        finish_test(1);

        start_test("back_to_back");
        repeat (8) begin
            fill_random();
            drive_frame(1'b0);
        end
        drive_tail(1'b0);
        finish_test(8);

        start_test("gapped");
        repeat (6) begin
            fill_random();
            drive_frame(1'b1);
        end
        drive_tail(1'b1);
        finish_test(6);

        start_test("mid_reset");
        repeat (2) begin
            fill_random();
            drive_frame(1'b0);
        end
        fill_random();
        drive_partial(TAIL_LEN, 1'b0);  // Reset lands inside this frame
        wait_outputs(2 * FRAME_LEN);
        check_count(2, out_cnt);
        pulse_reset();
        repeat (3) begin
            fill_random();
            drive_frame(1'b0);
        end
        drive_tail(1'b0);
        finish_test(3);

        start_test("full_scale");
        for (int n = 0; n < FRAME_LEN; n++) begin
            frame_buf[n].re = 16'h8000;
            frame_buf[n].im = 16'h8000;
        end
        drive_frame(1'b0);
        for (int n = 0; n < FRAME_LEN; n++) begin
            frame_buf[n].re = (n % 2 == 0) ? 16'sd32767 : -16'sd32767;
            frame_buf[n].im = -frame_buf[n].re;
        end
        drive_frame(1'b0);
        drive_tail(1'b0);
        finish_test(2);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
    input  logic rst_req,
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    logic por;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        por = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        por = 1'b0;
    end

    assign rst = por | rst_req;  // Power-on reset or a reset asked for by the test

endmodule

/* r22sdf_stage.sv */
module r22sdf_stage #(
    parameter int FRAME_LEN = 16
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic signed [fft_num_pkg::IN_WIDTH-1:0] din_re,
    input  logic signed [fft_num_pkg::IN_WIDTH-1:0] din_im,
    input  logic                                  din_valid,
    output logic signed [fft_num_pkg::IN_WIDTH+2:0] dout_re,
    output logic signed [fft_num_pkg::IN_WIDTH+2:0] dout_im,
    output logic                                  dout_valid
);

    fft_num_pkg::in_cplx_t  din;
    fft_num_pkg::bf1_cplx_t bf1_data;
    logic                   bf1_valid;
    fft_num_pkg::bf2_cplx_t bf2_data;
    logic                   bf2_valid;
    fft_num_pkg::twiddle_t  twiddle;
    fft_num_pkg::out_cplx_t out_data;

    assign din.re = din_re;
    assign din.im = din_im;

    sdf_bf1 #(
        .FRAME_LEN (FRAME_LEN)
    ) i_sdf_bf1 (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .din_valid  (din_valid),
        .dout       (bf1_data),
        .dout_valid (bf1_valid)
    );

    sdf_bf2 #(
        .FRAME_LEN (FRAME_LEN)
    ) i_sdf_bf2 (
        .clk        (clk),
        .rst        (rst),
        .din        (bf1_data),
        .din_valid  (bf1_valid),
        .dout       (bf2_data),
        .dout_valid (bf2_valid)
    );

    twiddle_gen #(
        .FRAME_LEN (FRAME_LEN)
    ) i_twiddle_gen (
        .clk          (clk),
        .rst          (rst),
        .sample_valid (bf2_valid),
        .twiddle      (twiddle)
    );

    twiddle_mult i_twiddle_mult (
        .clk        (clk),
        .rst        (rst),
        .din        (bf2_data),
        .din_valid  (bf2_valid),
        .twiddle    (twiddle),
        .dout       (out_data),
        .dout_valid (dout_valid)
    );

    assign dout_re = out_data.re;
    assign dout_im = out_data.im;

endmodule

/* twiddle_mult.sv */
module twiddle_mult (
    input  logic                   clk,
    input  logic                   rst,
    input  fft_num_pkg::bf2_cplx_t din,
    input  logic                   din_valid,
    input  fft_num_pkg::twiddle_t  twiddle,
    output fft_num_pkg::out_cplx_t dout,
    output logic                   dout_valid
);

    localparam int AW = fft_num_pkg::IN_WIDTH + 2;
    localparam int OW = fft_num_pkg::IN_WIDTH + 3;
    localparam int PW = AW + fft_num_pkg::TW_WIDTH;
    localparam int SW = PW + 1;

    logic signed [PW-1:0] p_rr;
    logic signed [PW-1:0] p_ii;
    logic signed [PW-1:0] p_ri;
    logic signed [PW-1:0] p_ir;
    logic signed [SW-1:0] s_re;
    logic signed [SW-1:0] s_im;
    logic                 valid_d1;

    always_ff @(posedge clk) begin
        if (din_valid) begin
            p_rr <= $signed(din.re) * $signed(twiddle.re);
            p_ii <= $signed(din.im) * $signed(twiddle.im);
            p_ri <= $signed(din.re) * $signed(twiddle.im);
            p_ir <= $signed(din.im) * $signed(twiddle.re);
        end
    end

    assign s_re = p_rr - p_ii;
    assign s_im = p_ri + p_ir;

    always_ff @(posedge clk) begin
        if (valid_d1) begin
            dout.re <= s_re[fft_num_pkg::TW_FRAC +: OW];  // Arithmetic shift by TW_FRAC
            dout.im <= s_im[fft_num_pkg::TW_FRAC +: OW];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d1   <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            valid_d1   <= din_valid;
            dout_valid <= valid_d1;
        end
    end

endmodule

/* twiddle_gen.sv */
module twiddle_gen #(
    parameter int FRAME_LEN = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sample_valid,
    output fft_num_pkg::twiddle_t twiddle
);

    localparam int  CNT_W = $clog2(FRAME_LEN);
    localparam int  R_W   = CNT_W - 2;
    localparam int  TW_W  = fft_num_pkg::TW_WIDTH;
    localparam real PI    = 3.14159265358979323846;
    localparam real SCALE = real'(1 << fft_num_pkg::TW_FRAC);

    typedef fft_num_pkg::twiddle_t [FRAME_LEN-1:0] tw_table_t;

    // W^e = exp(-j*2*pi*e/N) in fixed point, rounded to nearest
    function automatic tw_table_t build_table();
        tw_table_t tbl;
        real       ang;
        for (int e = 0; e < FRAME_LEN; e++) begin
            ang       = 2.0 * PI * e / FRAME_LEN;
            tbl[e].re = TW_W'(int'($cos(ang) * SCALE));
            tbl[e].im = TW_W'(int'(-$sin(ang) * SCALE));
        end
        return tbl;
    endfunction

    localparam tw_table_t TW_TABLE = build_table();

    logic [CNT_W-1:0]         cnt;
    logic [1:0]               q;
    logic [1:0]               k;
    logic [R_W-1:0]           r;
    sdf_ctrl_pkg::frame_idx_t expo;

    assign q    = cnt[CNT_W-1 -: 2];
    assign r    = cnt[R_W-1:0];
    assign k    = {q[0], q[1]};                    // Blocks leave in order 0, 2, 1, 3
    assign expo = sdf_ctrl_pkg::frame_idx_t'(r) * sdf_ctrl_pkg::frame_idx_t'(k);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (sample_valid) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign twiddle = TW_TABLE[expo[CNT_W-1:0]];  // r*k stays below FRAME_LEN

endmodule

/* sdf_bf2.sv */
module sdf_bf2 #(
    parameter int FRAME_LEN = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fft_num_pkg::bf1_cplx_t din,
    input  logic                   din_valid,
    output fft_num_pkg::bf2_cplx_t dout,
    output logic                   dout_valid
);

    localparam int CNT_W = $clog2(FRAME_LEN);
    localparam int Q_W   = CNT_W - 2;              // Offset bits within a quarter
    localparam int W2    = fft_num_pkg::IN_WIDTH + 2;

    logic [CNT_W-1:0]        cnt;
    logic [1:0]              quarter;
    sdf_ctrl_pkg::bf2_mode_e mode;
    logic                    primed;

    fft_num_pkg::bf2_cplx_t x_ext;
    fft_num_pkg::bf2_cplx_t fb;
    fft_num_pkg::bf2_cplx_t fb_next;
    fft_num_pkg::bf2_cplx_t out_next;

    assign x_ext.re = {din.re[W2-2], din.re};
    assign x_ext.im = {din.im[W2-2], din.im};
    assign quarter  = cnt[CNT_W-1 -: 2];

    always_comb begin
        case (mode)
            sdf_ctrl_pkg::BF2_SUM: begin
                fb_next.re  = fb.re - x_ext.re;
                fb_next.im  = fb.im - x_ext.im;
                out_next.re = fb.re + x_ext.re;
                out_next.im = fb.im + x_ext.im;
            end
            sdf_ctrl_pkg::BF2_ROT_SUM: begin
                // -j * (a + jb) = b - ja
                fb_next.re  = fb.re - x_ext.im;
                fb_next.im  = fb.im + x_ext.re;
                out_next.re = fb.re + x_ext.im;
                out_next.im = fb.im - x_ext.re;
            end
            default: begin
                fb_next  = x_ext;
                out_next = fb;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt        <= '0;
            mode       <= sdf_ctrl_pkg::BF2_FILL;
            primed     <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid & primed;
            if (din_valid) begin
                cnt <= cnt + 1'b1;
                if (cnt[Q_W-1:0] == '1) begin    // Last sample of a quarter
                    case (quarter)
                        2'd0: begin
                            mode   <= sdf_ctrl_pkg::BF2_SUM;
                            primed <= 1'b1;
                        end
                        2'd1:    mode <= sdf_ctrl_pkg::BF2_FILL;
                        2'd2:    mode <= sdf_ctrl_pkg::BF2_ROT_SUM;
                        default: mode <= sdf_ctrl_pkg::BF2_FILL;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (din_valid) begin
            dout <= out_next;
        end
    end

    feedback_delay #(
        .WIDTH (2 * W2),
        .DEPTH (FRAME_LEN / 4)
    ) i_feedback_delay (
        .clk  (clk),
        .rst  (rst),
        .en   (din_valid),
        .din  (fb_next),
        .dout (fb)
    );

endmodule

/* sdf_bf1.sv */
module sdf_bf1 #(
    parameter int FRAME_LEN = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fft_num_pkg::in_cplx_t  din,
    input  logic                   din_valid,
    output fft_num_pkg::bf1_cplx_t dout,
    output logic                   dout_valid
);

    localparam int CNT_W = $clog2(FRAME_LEN);
    localparam int W1    = fft_num_pkg::IN_WIDTH + 1;

    logic [CNT_W-1:0]        cnt;
    sdf_ctrl_pkg::bf1_mode_e mode;
    logic                    primed;

    fft_num_pkg::bf1_cplx_t x_ext;
    fft_num_pkg::bf1_cplx_t fb;
    fft_num_pkg::bf1_cplx_t fb_next;
    fft_num_pkg::bf1_cplx_t out_next;

    assign x_ext.re = {din.re[W1-2], din.re};  // Sign extend by one bit
    assign x_ext.im = {din.im[W1-2], din.im};

    always_comb begin
        if (mode == sdf_ctrl_pkg::BF1_FILL) begin
            fb_next  = x_ext;
            out_next = fb;                       // Differences of the previous frame
        end else begin
            fb_next.re  = fb.re - x_ext.re;
            fb_next.im  = fb.im - x_ext.im;
            out_next.re = fb.re + x_ext.re;
            out_next.im = fb.im + x_ext.im;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt        <= '0;
            mode       <= sdf_ctrl_pkg::BF1_FILL;
            primed     <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid & primed;
            if (din_valid) begin
                cnt <= cnt + 1'b1;               // Wraps at FRAME_LEN
                if (cnt[CNT_W-2:0] == '1) begin
                    if (!cnt[CNT_W-1]) begin
                        mode   <= sdf_ctrl_pkg::BF1_SUM;
                        primed <= 1'b1;          // First half frame stored
                    end else begin
                        mode <= sdf_ctrl_pkg::BF1_FILL;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (din_valid) begin
            dout <= out_next;
        end
    end

    feedback_delay #(
        .WIDTH (2 * W1),
        .DEPTH (FRAME_LEN / 2)
    ) i_feedback_delay (
        .clk  (clk),
        .rst  (rst),
        .en   (din_valid),
        .din  (fb_next),
        .dout (fb)
    );

endmodule

/* feedback_delay.sv */
module feedback_delay #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] line [DEPTH];

    // Advances only on valid samples, so gaps do not disturb alignment
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                line[i] <= '0;
            end
        end else if (en) begin
            line[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    assign dout = line[DEPTH-1];  // Oldest stored sample

endmodule

/* sdf_ctrl_pkg.sv */
package sdf_ctrl_pkg;

    localparam int MAX_LOG2_LEN = 8;  // Frames up to 256 samples

    typedef logic [MAX_LOG2_LEN-1:0] frame_idx_t;

    typedef enum logic {
        BF1_FILL,
        BF1_SUM
    } bf1_mode_e;

    typedef enum logic [1:0] {
        BF2_FILL,
        BF2_SUM,
        BF2_ROT_SUM                   // Sum with the -j rotated input
    } bf2_mode_e;

endpackage

/* fft_num_pkg.sv */
package fft_num_pkg;

    localparam int IN_WIDTH = 16;     // Input component width
    localparam int TW_WIDTH = 16;
    localparam int TW_FRAC  = 14;     // Twiddle fraction bits

    typedef struct packed {
        logic signed [IN_WIDTH-1:0] re;
        logic signed [IN_WIDTH-1:0] im;
    } in_cplx_t;

    typedef struct packed {
        logic signed [IN_WIDTH:0] re;     // One bit of growth after BF1
        logic signed [IN_WIDTH:0] im;
    } bf1_cplx_t;

    typedef struct packed {
        logic signed [IN_WIDTH+1:0] re;
        logic signed [IN_WIDTH+1:0] im;
    } bf2_cplx_t;

    typedef struct packed {
        logic signed [IN_WIDTH+2:0] re;   // Multiplier output after truncation
        logic signed [IN_WIDTH+2:0] im;
    } out_cplx_t;

    typedef struct packed {
        logic signed [TW_WIDTH-1:0] re;
        logic signed [TW_WIDTH-1:0] im;
    } twiddle_t;

endpackage
